/* source/segment_pkg.sv */
`default_nettype none

package segment_pkg;

	////////////////////////////////////////////////////////////
	// Display geometry.
	////////////////////////////////////////////////////////////

	localparam int num_segments = 6; // Segments per digit, dot excluded.
	localparam int num_digits = 4;

	////////////////////////////////////////////////////////////
	// Input conditioning.
	////////////////////////////////////////////////////////////

	localparam int sync_stages = 2; // Flip-flops ahead of any logic.
	localparam int debounce_cycles = 16; // Stable clocks before a switch level is taken.

	////////////////////////////////////////////////////////////
	// Types.
	////////////////////////////////////////////////////////////

	typedef logic [num_segments-1:0] seg_t; // Bit i drives segment i.
	typedef logic [2:0] pos_t; // Lit position, 0 to 5.
	typedef logic [1:0] digit_sel_t; // sw_h is the high bit.
	typedef logic [4:0] debounce_count_t;

	localparam pos_t max_position = pos_t'(num_segments - 1); // Wraps to 0 after this.

	// Display styles, stepped in this order by the mode button.
	typedef enum logic [1:0]
	{
		mode_single,
		mode_gap,
		mode_off
	} mode_t;

endpackage

`default_nettype wire

/* source/debouncer.sv */
`timescale 1ns/100ps
`default_nettype none

module debouncer
(
	input logic clk,
	input logic reset,
	input logic in,
	output logic out
);

	import segment_pkg::*;

	logic [sync_stages-1:0] sync_chain;
	logic synced;
	logic level_differs;
	logic accept;
	debounce_count_t stable_count;
	debounce_count_t stable_count_next;

	////////////////////////////////////////////////////////////
	// Synchronizer.
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sync_chain <= '0;
		end
		else
		begin
			sync_chain <= {sync_chain[sync_stages-2:0], in}; // Shift in at bit 0.
		end
	end

	assign synced = sync_chain[sync_stages-1];

	////////////////////////////////////////////////////////////
	// Stability counter.
	////////////////////////////////////////////////////////////

	assign level_differs = (synced != out);
	assign stable_count_next = stable_count + debounce_count_t'(1);

	// Sixteenth differing sample in a row.
	assign accept = level_differs && (stable_count_next == debounce_count_t'(debounce_cycles));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stable_count <= '0;
		end
		else if (!level_differs || accept)
		begin
			stable_count <= '0; // Glitch ended, or level taken.
		end
		else
		begin
			stable_count <= stable_count_next;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			out <= 1'b0;
		end
		else if (accept)
		begin
			out <= synced;
		end
	end

endmodule

`default_nettype wire

/* source/rising_edge.sv */
`timescale 1ns/100ps
`default_nettype none

module rising_edge
(
	input logic clk,
	input logic reset,
	input logic in,
	output logic out
);

	import segment_pkg::*;

	logic [sync_stages-1:0] sync_chain;
	logic synced;
	logic history; // Synced level one clock ago.

	assign synced = sync_chain[sync_stages-1];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sync_chain <= '0;
			history <= 1'b0;
			out <= 1'b0;
		end
		else
		begin
			sync_chain <= {sync_chain[sync_stages-2:0], in};
			history <= synced;
			out <= synced && !history; // High for the first clock of a press only.
		end
	end

endmodule

`default_nettype wire

/* source/segment_driver_c.sv */
`timescale 1ns/100ps
`default_nettype none

module segment_driver_c
(
	input logic clk,
	input logic reset,

	input logic btn_next_segment_re,
	input logic btn_mode_re,

	output segment_pkg::seg_t segments
);

	import segment_pkg::*;

	pos_t position;
	pos_t position_next;
	mode_t mode;
	mode_t mode_next;

	// Segment levels for one position and style.
	function automatic seg_t segment_pattern(input pos_t pos, input mode_t style);
		seg_t lit;
		seg_t pattern;
		lit = seg_t'(1) << pos;
		case (style)
			mode_single:
			begin
				pattern = lit;
			end
			mode_gap:
			begin
				pattern = ~lit; // Everything but the position.
			end
			default:
			begin
				pattern = '0;
			end
		endcase
		return pattern;
	endfunction

	////////////////////////////////////////////////////////////
	// Next position and mode.
	////////////////////////////////////////////////////////////

	always_comb
	begin
		position_next = position;
		if (btn_next_segment_re)
		begin
			if (position == max_position)
			begin
				position_next = '0;
			end
			else
			begin
				position_next = position + pos_t'(1);
			end
		end
	end

	always_comb
	begin
		mode_next = mode;
		if (btn_mode_re)
		begin
			case (mode)
				mode_single:
				begin
					mode_next = mode_gap;
				end
				mode_gap:
				begin
					mode_next = mode_off;
				end
				default:
				begin
					mode_next = mode_single; // Off wraps back.
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// State and output registers.
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			position <= '0;
			mode <= mode_single;
			segments <= segment_pattern('0, mode_single);
		end
		else
		begin
			position <= position_next;
			mode <= mode_next;
			segments <= segment_pattern(position_next, mode_next); // Shows the update at once.
		end
	end

endmodule

`default_nettype wire

/* source/segment_driver_d.sv */
`timescale 1ns/100ps
`default_nettype none

module segment_driver_d
(
	input logic clk,
	input logic reset,

	input logic btn_next_segment,
	input logic btn_mode,

	input logic sw_h,
	input logic sw_l,

	output segment_pkg::seg_t segments1,
	output logic dot1,
	output segment_pkg::seg_t segments2,
	output logic dot2,
	output segment_pkg::seg_t segments3,
	output logic dot3,
	output segment_pkg::seg_t segments4,
	output logic dot4
);

	import segment_pkg::*;

	digit_sel_t active;
	logic next_segment_pulse;
	logic mode_pulse;

	logic [num_digits-1:0] digit_enable;
	logic [num_digits-1:0] next_segment_gated;
	logic [num_digits-1:0] mode_gated;

	////////////////////////////////////////////////////////////
	// Input conditioning.
	////////////////////////////////////////////////////////////

	debouncer debouncer_h
	(
		.clk(clk),
		.reset(reset),
		.in(sw_h),
		.out(active[1])
	);

	debouncer debouncer_l
	(
		.clk(clk),
		.reset(reset),
		.in(sw_l),
		.out(active[0])
	);

	rising_edge re_next_segment
	(
		.clk(clk),
		.reset(reset),
		.in(btn_next_segment),
		.out(next_segment_pulse)
	);

	rising_edge re_mode
	(
		.clk(clk),
		.reset(reset),
		.in(btn_mode),
		.out(mode_pulse)
	);

	////////////////////////////////////////////////////////////
	// Digit select.
	////////////////////////////////////////////////////////////

	always_comb
	begin
		for (int k = 0; k < num_digits; k++)
		begin
			digit_enable[k] = (active == digit_sel_t'(k));
		end
	end

	// A pulse reaches only the digit selected in that cycle.
	assign next_segment_gated = {num_digits{next_segment_pulse}} & digit_enable;
	assign mode_gated = {num_digits{mode_pulse}} & digit_enable;

	assign dot1 = digit_enable[0];
	assign dot2 = digit_enable[1];
	assign dot3 = digit_enable[2];
	assign dot4 = digit_enable[3];

	////////////////////////////////////////////////////////////
	// Digit drivers.
	////////////////////////////////////////////////////////////

	segment_driver_c segment_driver_c_0
	(
		.clk(clk),
		.reset(reset),

		.btn_next_segment_re(next_segment_gated[0]),
		.btn_mode_re(mode_gated[0]),

		.segments(segments1)
	);

	segment_driver_c segment_driver_c_1
	(
		.clk(clk),
		.reset(reset),

		.btn_next_segment_re(next_segment_gated[1]),
		.btn_mode_re(mode_gated[1]),

		.segments(segments2)
	);

	segment_driver_c segment_driver_c_2
	(
		.clk(clk),
		.reset(reset),

		.btn_next_segment_re(next_segment_gated[2]),
		.btn_mode_re(mode_gated[2]),

		.segments(segments3)
	);

	segment_driver_c segment_driver_c_3
	(
		.clk(clk),
		.reset(reset),

		.btn_next_segment_re(next_segment_gated[3]),
		.btn_mode_re(mode_gated[3]),

		.segments(segments4)
	);

endmodule

`default_nettype wire

/* test/segment_driver_d_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module segment_driver_d_assertions
(
	input logic clk,
	input logic reset,
	input segment_pkg::seg_t segments1,
	input segment_pkg::seg_t segments2,
	input segment_pkg::seg_t segments3,
	input segment_pkg::seg_t segments4,
	input logic dot1,
	input logic dot2,
	input logic dot3,
	input logic dot4
);

	import segment_pkg::*;

	// Dark, a single lit segment, or a single gap.
	function automatic logic shape_ok(input seg_t levels);
		return (levels == '0) || $onehot(levels) || $onehot(~levels);
	endfunction

	assert property (@(posedge clk) disable iff (reset) $onehot({dot4, dot3, dot2, dot1}))
	else $error("dots are not one-hot: %b", {dot4, dot3, dot2, dot1});

	assert property (@(posedge clk) disable iff (reset) shape_ok(segments1))
	else $error("segments1 has an illegal pattern: %b", segments1);

	assert property (@(posedge clk) disable iff (reset) shape_ok(segments2))
	else $error("segments2 has an illegal pattern: %b", segments2);

	assert property (@(posedge clk) disable iff (reset) shape_ok(segments3))
	else $error("segments3 has an illegal pattern: %b", segments3);

	assert property (@(posedge clk) disable iff (reset) shape_ok(segments4))
	else $error("segments4 has an illegal pattern: %b", segments4);

endmodule

`default_nettype wire

/* test/segment_driver_d_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module segment_driver_d_tb;

	import segment_pkg::*;

	localparam int clk_period = 8;
	localparam int switch_wait = 22; // Debounce latency of 18 plus margin.
	localparam int press_wait = 6; // Press latency of 4 plus margin.
	localparam int max_directed_ops = 40;
	localparam int random_ops = 300;
	localparam int timeout_ns = (max_directed_ops + random_ops) * 40 * clk_period + 1000;

	logic clk = 1'b0;
	logic reset;
	logic btn_next_segment;
	logic btn_mode;
	logic sw_h;
	logic sw_l;
	seg_t segments1;
	seg_t segments2;
	seg_t segments3;
	seg_t segments4;
	logic dot1;
	logic dot2;
	logic dot3;
	logic dot4;

	seg_t segments_actual [num_digits];
	logic [num_digits-1:0] dots_actual;

	// Reference model state. Mode 0 is single, 1 gap, 2 off.
	int model_pos [num_digits];
	int model_mode [num_digits];
	int model_active;

	int errors = 0;
	int checks = 0;
	string check_name;
	event check_now;

	segment_driver_d segment_driver_d_inst
	(
		.clk(clk),
		.reset(reset),
		.btn_next_segment(btn_next_segment),
		.btn_mode(btn_mode),
		.sw_h(sw_h),
		.sw_l(sw_l),
		.segments1(segments1),
		.dot1(dot1),
		.segments2(segments2),
		.dot2(dot2),
		.segments3(segments3),
		.dot3(dot3),
		.segments4(segments4),
		.dot4(dot4)
	);

	bind segment_driver_d segment_driver_d_assertions segment_driver_d_assertions_inst (.*);

	assign segments_actual[0] = segments1;
	assign segments_actual[1] = segments2;
	assign segments_actual[2] = segments3;
	assign segments_actual[3] = segments4;
	assign dots_actual = {dot4, dot3, dot2, dot1};

	always #(clk_period / 2) clk = ~clk;

	function automatic seg_t expected_segments(input int position, input int mode);
		seg_t levels;
		for (int i = 0; i < num_segments; i++)
		begin
			if (mode == 0)
			begin
				levels[i] = (i == position);
			end
			else if (mode == 1)
			begin
				levels[i] = (i != position);
			end
			else
			begin
				levels[i] = 1'b0; // Off shows nothing.
			end
		end
		return levels;
	endfunction

	////////////////////////////////////////////////////////////
	// Comparison.
	////////////////////////////////////////////////////////////

	always @(check_now)
	begin
		seg_t expected;
		logic [num_digits-1:0] expected_dots;
		expected_dots = 4'b0001 << model_active;
		for (int k = 0; k < num_digits; k++)
		begin
			expected = expected_segments(model_pos[k], model_mode[k]);
			assert (segments_actual[k] == expected)
			else
			begin
				errors++;
				$display("MISMATCH %s: segments%0d expected %b actual %b",
					check_name, k + 1, expected, segments_actual[k]);
			end
		end
		assert (dots_actual == expected_dots)
		else
		begin
			errors++;
			$display("MISMATCH %s: dots expected %b actual %b",
				check_name, expected_dots, dots_actual);
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks are entered just after a falling edge.
	////////////////////////////////////////////////////////////

	task automatic wait_cycles(input int cycles);
		repeat (cycles) @(negedge clk);
	endtask

	task automatic compare_outputs(input string name);
		check_name = name;
		checks++;
		->check_now;
	endtask

	task automatic press(input bit is_mode, input int hold, input string name);
		if (is_mode)
		begin
			btn_mode = 1'b1;
		end
		else
		begin
			btn_next_segment = 1'b1;
		end
		wait_cycles(hold);
		btn_mode = 1'b0;
		btn_next_segment = 1'b0;
		wait_cycles(press_wait);
		if (is_mode)
		begin
			model_mode[model_active] = (model_mode[model_active] + 1) % 3;
		end
		else
		begin
			model_pos[model_active] = (model_pos[model_active] + 1) % num_segments;
		end
		compare_outputs(name);
	endtask

	task automatic set_switches(input int sel, input string name);
		sw_h = sel[1];
		sw_l = sel[0];
		wait_cycles(switch_wait);
		model_active = sel;
		compare_outputs(name);
	endtask

	task automatic glitch_switch(input int cycles, input string name);
		sw_l = ~sw_l;
		wait_cycles(cycles);
		sw_l = ~sw_l;
		wait_cycles(sync_stages); // Last glitch sample has passed the synchronizer.
		compare_outputs(name);
		wait_cycles(switch_wait);
		compare_outputs(name);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence.
	////////////////////////////////////////////////////////////

	initial
	begin
		int unsigned seed_value;
		int choice;
		seed_value = $urandom(32'h9cfb);
		reset = 1'b1;
		btn_next_segment = 1'b0;
		btn_mode = 1'b0;
		sw_h = 1'b0;
		sw_l = 1'b0;
		model_active = 0;
		for (int k = 0; k < num_digits; k++)
		begin
			model_pos[k] = 0;
			model_mode[k] = 0;
		end
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		wait_cycles(2);
		compare_outputs("reset_state");

		for (int sel = 1; sel <= num_digits; sel++)
		begin
			set_switches(sel % num_digits, "digit_select");
		end
		glitch_switch(8, "switch_glitch");

		set_switches(1, "advance_select");
		repeat (7) press(1'b0, 1, "segment_advance");

		set_switches(2, "mode_select");
		press(1'b1, 2, "mode_to_gap");
		press(1'b0, 1, "advance_in_gap");
		press(1'b1, 2, "mode_to_off");
		press(1'b0, 3, "advance_in_off");
		press(1'b0, 1, "advance_in_off");
		press(1'b1, 1, "mode_to_single");

		set_switches(3, "hold_select");
		press(1'b0, 24, "long_hold");
		press(1'b1, 20, "long_hold");

		for (int op = 0; op < random_ops; op++)
		begin
			choice = int'($urandom_range(0, 9));
			if (choice < 5)
			begin
				press(1'b0, int'($urandom_range(1, 12)), "random_next");
			end
			else if (choice < 8)
			begin
				press(1'b1, int'($urandom_range(1, 12)), "random_mode");
			end
			else
			begin
				set_switches(int'($urandom_range(0, 3)), "random_switch");
			end
		end

		wait_cycles(1);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
		begin
			$display("Simulation finished: PASS");
		end
		else
		begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial
	begin
		#(timeout_ns);
		$display("Timeout: the test sequence did not complete in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
source/segment_pkg.sv
source/debouncer.sv
source/rising_edge.sv
source/segment_driver_c.sv
source/segment_driver_d.sv
test/segment_driver_d_assertions.sv
test/segment_driver_d_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the segment display testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module segment_driver_d_tb \
	--Mdir obj_dir \
	-o segment_driver_d_sim \
	-f flist.f

./obj_dir/segment_driver_d_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
	echo "Test run passed."
	exit 0
else
	echo "Test run failed, see sim.log."
	exit 1
fi
